// ==== Makefile ====
# Verilator build and run for the uncore testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = uncoreTb
FILELIST = uncore.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

# Pass only if the pass message reached the log
run: build
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== src/ahbDecoder.sv ====
// AHB-Lite address decoder for the four uncore regions
// Address-phase to data-phase register and byte-lane generation

`timescale 1ns/100ps
`default_nettype none

`include "uncore_params.svh"

module ahbDecoder import uncorePkg::*; (
  input  logic        HCLK,
  input  logic        arstN,
  // Address phase
  input  logic [31:0] HADDR,
  input  htransT      HTRANS,
  input  hsizeT       HSIZE,
  input  logic        HWRITE,
  // Data phase view
  output regionSelT   selD,
  output logic        faultD,
  output logic        writeD,
  output logic [13:0] wordAddrD,
  output logic [3:0]  byteEnD
);

  regionSelT   hitSel;
  logic        active;
  logic [3:0]  byteEnA;

  ////////////////////
  // Address decode
  ////////////////////

  // Only NONSEQ and SEQ carry a transfer
  assign active = (HTRANS == TransNonseq) || (HTRANS == TransSeq);

  // Regions do not overlap, so order does not matter
  always_comb begin
    hitSel = SelNone;
    if ((HADDR & ~`UNCORE_TIMRANGE) == `UNCORE_TIMBASE) begin
      hitSel = SelTim;
    end else if ((HADDR & ~`UNCORE_BOOTRANGE) == `UNCORE_BOOTBASE) begin
      hitSel = SelBoot;
    end else if ((HADDR & ~`UNCORE_CLINTRANGE) == `UNCORE_CLINTBASE) begin
      hitSel = SelClint;
    end else if ((HADDR & ~`UNCORE_GPIORANGE) == `UNCORE_GPIOBASE) begin
      hitSel = SelGpio;
    end
  end

  // Byte lanes from size and low address bits
  always_comb begin
    case (HSIZE)
      SizeByte: byteEnA = 4'b0001 << HADDR[1:0];
      SizeHalf: byteEnA = HADDR[1] ? 4'b1100 : 4'b0011;
      default:  byteEnA = 4'b1111;
    endcase
  end

  ////////////////////
  // Data phase register
  ////////////////////

  // Control half, idle slots become SelNone with no fault
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      selD   <= SelNone;
      faultD <= 1'b0;
      writeD <= 1'b0;
    end else begin
      selD   <= active ? hitSel : SelNone;
      faultD <= active && (hitSel == SelNone);
      writeD <= active && HWRITE;
    end
  end

  // Address and lanes only matter under a valid select
  always_ff @(posedge HCLK) begin
    wordAddrD <= HADDR[15:2];
    byteEnD   <= byteEnA;
  end

endmodule

`default_nettype wire

// ==== src/clint.sv ====
// Core-local interruptor with 64-bit mtime and mtimecmp
// msip register, timer and software interrupt outputs

`timescale 1ns/100ps
`default_nettype none

module clint import uncorePkg::*; (
  input  logic        HCLK,
  input  logic        arstN,
  input  logic        sel,
  input  logic        writeD,
  input  logic [13:0] wordAddrD,
  input  logic [3:0]  byteEnD,
  input  logic [31:0] HWDATA,
  output logic [31:0] readData,
  output logic        TimerInt,
  output logic        SwInt
);

  // Word offsets of the register map
  localparam logic [13:0] MsipWord    = 14'h0000;
  localparam logic [13:0] CmpLoWord   = 14'h1000;
  localparam logic [13:0] CmpHiWord   = 14'h1001;
  localparam logic [13:0] MtimeLoWord = 14'h2FFE;
  localparam logic [13:0] MtimeHiWord = 14'h2FFF;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        msip;
  logic        wrEn;

  assign wrEn = sel && writeD;

  // Replace only the enabled bytes of a register word
  function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord,
                                             input logic [31:0] newWord,
                                             input logic [3:0]  lanes);
    logic [31:0] merged;
    merged = oldWord;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        merged[8*i +: 8] = newWord[8*i +: 8];
      end
    end
    return merged;
  endfunction

  ////////////////////
  // Timer
  ////////////////////

  // Free-running count, a bus write wins over the increment
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      mtime <= '0;
    end else if (wrEn && (wordAddrD == MtimeLoWord)) begin
      mtime <= {mtime[63:32], mergeLanes(mtime[31:0], HWDATA, byteEnD)};
    end else if (wrEn && (wordAddrD == MtimeHiWord)) begin
      mtime <= {mergeLanes(mtime[63:32], HWDATA, byteEnD), mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // Compare value and software interrupt bit
  // All-ones compare keeps the timer interrupt quiet out of reset
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      mtimecmp <= '1;
      msip     <= 1'b0;
    end else if (wrEn) begin
      if (wordAddrD == CmpLoWord) begin
        mtimecmp[31:0] <= mergeLanes(mtimecmp[31:0], HWDATA, byteEnD);
      end
      if (wordAddrD == CmpHiWord) begin
        mtimecmp[63:32] <= mergeLanes(mtimecmp[63:32], HWDATA, byteEnD);
      end
      if ((wordAddrD == MsipWord) && byteEnD[0]) begin
        msip <= HWDATA[0];
      end
    end
  end

  ////////////////////
  // Read and interrupts
  ////////////////////

  always_comb begin
    case (wordAddrD)
      MsipWord:    readData = {31'd0, msip};
      CmpLoWord:   readData = mtimecmp[31:0];
      CmpHiWord:   readData = mtimecmp[63:32];
      MtimeLoWord: readData = mtime[31:0];
      MtimeHiWord: readData = mtime[63:32];
      default:     readData = '0;
    endcase
  end

  // Level interrupts straight from the registers
  assign TimerInt = (mtime >= mtimecmp);
  assign SwInt    = msip;

endmodule

`default_nettype wire

// ==== src/dtim.sv ====
// Word-organized RAM slave with byte-lane writes
// Used for both the data TIM and the boot memory

`timescale 1ns/100ps
`default_nettype none

module dtim import uncorePkg::*; #(
  parameter int DEPTH = 1024
) (
  input  logic        HCLK,
  input  logic        sel,
  input  logic        writeD,
  input  logic [13:0] wordAddrD,
  input  logic [3:0]  byteEnD,
  input  logic [31:0] HWDATA,
  output logic [31:0] readData
);

  // Index width, the address wraps at DEPTH
  localparam int AW = $clog2(DEPTH);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] index;
  logic          wrEn;

  assign index = wordAddrD[AW-1:0];
  assign wrEn  = sel && writeD;

  ////////////////////
  // Write port
  ////////////////////

  // Lanes written at the end of the data phase
  always_ff @(posedge HCLK) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (wrEn && byteEnD[lane]) begin
        mem[index][8*lane +: 8] <= HWDATA[8*lane +: 8];
      end
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Combinational read in the data phase
  // A write one cycle earlier is already in the array
  assign readData = mem[index];

endmodule

`default_nettype wire

// ==== src/gpio.sv ====
// 32-bit GPIO slave with two-flop input synchronizer
// Output-enable and output-value registers with byte-lane writes

`timescale 1ns/100ps
`default_nettype none

module gpio import uncorePkg::*; (
  input  logic        HCLK,
  input  logic        arstN,
  input  logic        sel,
  input  logic        writeD,
  input  logic [13:0] wordAddrD,
  input  logic [3:0]  byteEnD,
  input  logic [31:0] HWDATA,
  input  logic [31:0] GPIOPinsIn,
  output logic [31:0] readData,
  output logic [31:0] GPIOPinsOut,
  output logic [31:0] GPIOPinsEn
);

  // Word offsets, input 0x00, enable 0x08, output 0x0C
  localparam logic [13:0] InWord  = 14'h0000;
  localparam logic [13:0] EnWord  = 14'h0002;
  localparam logic [13:0] OutWord = 14'h0003;

  logic [31:0] syncMeta;
  logic [31:0] syncIn;
  logic        wrEn;

  assign wrEn = sel && writeD;

  ////////////////////
  // Input synchronizer
  ////////////////////

  // Pins are asynchronous to HCLK
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      syncMeta <= '0;
      syncIn   <= '0;
    end else begin
      syncMeta <= GPIOPinsIn;
      syncIn   <= syncMeta;
    end
  end

  ////////////////////
  // Control registers
  ////////////////////

  // Pins drive nothing until software enables them
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      GPIOPinsEn  <= '0;
      GPIOPinsOut <= '0;
    end else if (wrEn) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byteEnD[lane] && (wordAddrD == EnWord)) begin
          GPIOPinsEn[8*lane +: 8] <= HWDATA[8*lane +: 8];
        end
        if (byteEnD[lane] && (wordAddrD == OutWord)) begin
          GPIOPinsOut[8*lane +: 8] <= HWDATA[8*lane +: 8];
        end
      end
    end
  end

  // Read back, input register is read-only
  always_comb begin
    case (wordAddrD)
      InWord:  readData = syncIn;
      EnWord:  readData = GPIOPinsEn;
      OutWord: readData = GPIOPinsOut;
      default: readData = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/uncore.sv ====
// Uncore top level, AHB-Lite slave set beside the core
// Decoder, TIM, boot memory, CLINT, GPIO and the read/response mux

`timescale 1ns/100ps
`default_nettype none

`include "uncore_params.svh"

module uncore import uncorePkg::*; (
  input  logic                   HCLK,
  input  logic                   arstN,
  // AHB-Lite slave port
  input  logic [31:0]            HADDR,
  input  htransT                 HTRANS,
  input  hsizeT                  HSIZE,
  input  logic                   HWRITE,
  input  logic [`UNCORE_AHBW-1:0] HWDATA,
  output logic [`UNCORE_AHBW-1:0] HRDATA,
  output logic                   HREADY,
  output logic                   HRESP,
  // Fault to the core
  output logic                   DataAccessFault,
  // Interrupts
  output logic                   TimerInt,
  output logic                   SwInt,
  // GPIO pins
  input  logic [31:0]            GPIOPinsIn,
  output logic [31:0]            GPIOPinsOut,
  output logic [31:0]            GPIOPinsEn
);

  regionSelT              selD;
  logic                   faultD;
  logic                   writeD;
  logic [13:0]            wordAddrD;
  logic [3:0]             byteEnD;
  logic [`UNCORE_AHBW-1:0] timRead, bootRead, clintRead, gpioRead;

  ////////////////////
  // Decode
  ////////////////////

  ahbDecoder i_decoder (
    .HCLK, .arstN, .HADDR, .HTRANS, .HSIZE, .HWRITE,
    .selD, .faultD, .writeD, .wordAddrD, .byteEnD
  );

  ////////////////////
  // Slaves
  ////////////////////

  // Each slave sees its select only in the data phase
  dtim #(.DEPTH(`UNCORE_TIMDEPTH)) tim (
    .HCLK, .sel(selD == SelTim), .writeD, .wordAddrD, .byteEnD, .HWDATA,
    .readData(timRead)
  );

  dtim #(.DEPTH(`UNCORE_BOOTDEPTH)) bootTim (
    .HCLK, .sel(selD == SelBoot), .writeD, .wordAddrD, .byteEnD, .HWDATA,
    .readData(bootRead)
  );

  clint i_clint (
    .HCLK, .arstN, .sel(selD == SelClint), .writeD, .wordAddrD, .byteEnD, .HWDATA,
    .readData(clintRead), .TimerInt, .SwInt
  );

  gpio i_gpio (
    .HCLK, .arstN, .sel(selD == SelGpio), .writeD, .wordAddrD, .byteEnD, .HWDATA,
    .GPIOPinsIn, .readData(gpioRead), .GPIOPinsOut, .GPIOPinsEn
  );

  ////////////////////
  // Read and response
  ////////////////////

  // Unmapped and idle data phases return zero
  always_comb begin
    case (selD)
      SelTim:   HRDATA = timRead;
      SelBoot:  HRDATA = bootRead;
      SelClint: HRDATA = clintRead;
      SelGpio:  HRDATA = gpioRead;
      default:  HRDATA = '0;
    endcase
  end

  // Zero wait states everywhere
  assign HREADY          = 1'b1;
  // Fault is a single data-phase level
  assign HRESP           = faultD;
  assign DataAccessFault = faultD;

endmodule

`default_nettype wire

// ==== src/uncorePkg.sv ====
// Shared bus types for the uncore
// Region select, AHB transfer type and transfer size enums

`default_nettype none

package uncorePkg;

  ////////////////////
  // Region select
  ////////////////////

  // Slave addressed by the transfer now in its data phase
  typedef enum logic [2:0] {
    SelNone  = 3'd0,
    SelTim   = 3'd1,
    SelBoot  = 3'd2,
    SelClint = 3'd3,
    SelGpio  = 3'd4
  } regionSelT;

  ////////////////////
  // AHB encodings
  ////////////////////

  // HTRANS values as in the AHB-Lite spec
  typedef enum logic [1:0] {
    TransIdle   = 2'b00,
    TransBusy   = 2'b01,
    TransNonseq = 2'b10,
    TransSeq    = 2'b11
  } htransT;

  // HSIZE values, nothing wider than the 32-bit bus
  typedef enum logic [2:0] {
    SizeByte = 3'b000,
    SizeHalf = 3'b001,
    SizeWord = 3'b010
  } hsizeT;

endpackage

`default_nettype wire

// ==== src/uncore_params.svh ====
// Bus width, region base addresses and range masks
// Memory depths in 32-bit words for the two RAMs

`ifndef UNCORE_PARAMS_SVH
`define UNCORE_PARAMS_SVH

////////////////////
// Bus
////////////////////

// AHB data width
`define UNCORE_AHBW 32

////////////////////
// Address map
////////////////////

// A region hits when the address with its range bits cleared equals the base
`define UNCORE_TIMBASE    32'h8000_0000
`define UNCORE_TIMRANGE   32'h0000_0FFF
`define UNCORE_BOOTBASE   32'h0000_1000
`define UNCORE_BOOTRANGE  32'h0000_03FF
`define UNCORE_CLINTBASE  32'h0200_0000
`define UNCORE_CLINTRANGE 32'h0000_FFFF
`define UNCORE_GPIOBASE   32'h1006_0000
`define UNCORE_GPIORANGE  32'h0000_00FF

// Depths in words, 4 KiB TIM and 1 KiB boot memory
`define UNCORE_TIMDEPTH  1024
`define UNCORE_BOOTDEPTH 256

`endif

// ==== tests/uncoreTb.sv ====
// Directed testbench for the uncore AHB-Lite slave set
// Pipelined bus tasks, reference models, compare tasks and watchdog

`timescale 1ns/100ps
`default_nettype none

`include "uncore_params.svh"

module uncoreTb import uncorePkg::*; ();

  // Watchdog length from the transfers issued by all tests
  localparam int NumXfers      = 74;
  localparam int TimeoutCycles = (NumXfers * 40 + 3) * 2;

  // Register addresses from the CLINT and GPIO maps
  localparam logic [31:0] MsipAddr    = `UNCORE_CLINTBASE + 32'h0000;
  localparam logic [31:0] CmpLoAddr   = `UNCORE_CLINTBASE + 32'h4000;
  localparam logic [31:0] CmpHiAddr   = `UNCORE_CLINTBASE + 32'h4004;
  localparam logic [31:0] MtimeLoAddr = `UNCORE_CLINTBASE + 32'hBFF8;
  localparam logic [31:0] GpioInAddr  = `UNCORE_GPIOBASE + 32'h00;
  localparam logic [31:0] GpioEnAddr  = `UNCORE_GPIOBASE + 32'h08;
  localparam logic [31:0] GpioOutAddr = `UNCORE_GPIOBASE + 32'h0C;

  logic        HCLK = 1'b0;
  logic        arstN;
  logic [31:0] HADDR;
  htransT      HTRANS;
  hsizeT       HSIZE;
  logic        HWRITE;
  logic [31:0] HWDATA;
  logic [31:0] HRDATA;
  logic        HREADY, HRESP, DataAccessFault, TimerInt, SwInt;
  logic [31:0] GPIOPinsIn, GPIOPinsOut, GPIOPinsEn;

  int          seed = 92235;
  // Write data owed to the data phase of the last address phase
  logic [31:0] pendWdata;
  // Data phase results of the previous cycle
  logic [31:0] lastRdata;
  logic        lastResp;
  logic        lastFault;
  // Memory model keyed by byte address of the word
  logic [31:0] memModel [logic [31:0]];

  uncore i_dut (.*);

  bind uncore uncore_asserts i_asserts (.*);

  always #2 HCLK = ~HCLK;

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    #(TimeoutCycles * 4);
    $display("Watchdog expired after %0d cycles, a test hung", TimeoutCycles);
    $display("TESTS FAILED");
    $fatal(1, "Run aborted by watchdog");
  end

  ////////////////////
  // Assertion monitor
  ////////////////////

  // Sticky flags from the bound bus checker
  always @(posedge i_dut.i_asserts.anyFail) begin
    $display("A bound bus assertion failed at %0t", $time);
    $display("TESTS FAILED");
    $fatal(1, "Run aborted by assertion failure");
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic failNow(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "Stopping at first mismatch");
  endtask

  task automatic checkData(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      failNow($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      failNow($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  task automatic checkSel(input string what, input regionSelT got, input regionSelT exp);
    if (got !== exp) begin
      failNow($sformatf("%s selected %s, expected %s", what, got.name(), exp.name()));
    end
  endtask

  ////////////////////
  // Reference models
  ////////////////////

  // Regions as inclusive address ranges
  function automatic regionSelT modelRegion(input logic [31:0] addr);
    if (addr >= `UNCORE_TIMBASE && addr <= `UNCORE_TIMBASE + `UNCORE_TIMRANGE) begin
      return SelTim;
    end
    if (addr >= `UNCORE_BOOTBASE && addr <= `UNCORE_BOOTBASE + `UNCORE_BOOTRANGE) begin
      return SelBoot;
    end
    if (addr >= `UNCORE_CLINTBASE && addr <= `UNCORE_CLINTBASE + `UNCORE_CLINTRANGE) begin
      return SelClint;
    end
    if (addr >= `UNCORE_GPIOBASE && addr <= `UNCORE_GPIOBASE + `UNCORE_GPIORANGE) begin
      return SelGpio;
    end
    return SelNone;
  endfunction

  // Merge only the lanes a transfer of this size and address touches
  function automatic logic [31:0] mergeModel(input logic [31:0] oldWord,
                                             input logic [31:0] newWord,
                                             input logic [31:0] addr,
                                             input hsizeT       size);
    logic [31:0] mask;
    case (size)
      SizeByte: mask = 32'h0000_00FF << (8 * addr[1:0]);
      SizeHalf: mask = 32'h0000_FFFF << (16 * addr[1]);
      default:  mask = 32'hFFFF_FFFF;
    endcase
    return (oldWord & ~mask) | (newWord & mask);
  endfunction

  ////////////////////
  // Bus tasks
  ////////////////////

  // One bus cycle closes the previous data phase and opens a new address phase
  task automatic stepBus(input logic [31:0] addr, input logic write, input hsizeT size,
                         input htransT trans, input logic [31:0] wdata);
    @(negedge HCLK);
    lastRdata = HRDATA;
    lastResp  = HRESP;
    lastFault = DataAccessFault;
    HWDATA    = pendWdata;
    HADDR     = addr;
    HWRITE    = write;
    HSIZE     = size;
    HTRANS    = trans;
    pendWdata = wdata;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) stepBus(32'h0, 1'b0, SizeWord, TransIdle, 32'h0);
  endtask

  // Data goes out in the following cycle, so writes can go back to back
  task automatic busWrite(input logic [31:0] addr, input hsizeT size, input logic [31:0] data);
    stepBus(addr, 1'b1, size, TransNonseq, data);
  endtask

  task automatic busRead(input logic [31:0] addr, output logic [31:0] data);
    stepBus(addr, 1'b0, SizeWord, TransNonseq, 32'h0);
    idleCycles(1);
    checkSel($sformatf("Read of %h", addr), i_dut.selD, modelRegion(addr));
    data = lastRdata;
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic memTest(input logic [31:0] base, input int depth);
    logic [31:0] addrs [8];
    logic [31:0] data;
    logic [31:0] got;
    for (int i = 0; i < 8; i++) begin
      addrs[i] = base + 4 * ($unsigned($random(seed)) % depth);
      data = $random(seed);
      memModel[addrs[i]] = data;
      busWrite(addrs[i], SizeWord, data);
    end
    for (int i = 0; i < 8; i++) begin
      busRead(addrs[i], got);
      checkData($sformatf("Word at %h", addrs[i]), got, memModel[addrs[i]]);
    end
    // Read address phase inside the write data phase
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      memModel[addrs[i]] = data;
      busWrite(addrs[i], SizeWord, data);
      busRead(addrs[i], got);
      checkData($sformatf("Read after write at %h", addrs[i]), got, data);
    end
  endtask

  task automatic partialWrite(input logic [31:0] addr, input hsizeT size);
    logic [31:0] word;
    logic [31:0] data;
    logic [31:0] got;
    word = {addr[31:2], 2'b00};
    // Known full word first, so every lane has a model value
    if (!memModel.exists(word)) begin
      memModel[word] = $random(seed);
      busWrite(word, SizeWord, memModel[word]);
    end
    data = $random(seed);
    memModel[word] = mergeModel(memModel[word], data, addr, size);
    busWrite(addr, size, data);
    busRead(word, got);
    checkData($sformatf("Word %h after %s write at %h", word, size.name(), addr),
              got, memModel[word]);
  endtask

  task automatic unmappedTest();
    logic [31:0] got;
    busRead(32'h4000_0000, got);
    checkBit("HRESP on unmapped read", lastResp, 1'b1);
    checkBit("DataAccessFault on unmapped read", lastFault, 1'b1);
    checkData("Unmapped read data", got, 32'h0);
    busWrite(32'h4000_0004, SizeWord, 32'hDEAD_BEEF);
    idleCycles(1);
    checkBit("HRESP on unmapped write", lastResp, 1'b1);
    // Same address without an active transfer
    stepBus(32'h4000_0000, 1'b0, SizeWord, TransIdle, 32'h0);
    idleCycles(1);
    checkSel("Idle transfer", i_dut.selD, SelNone);
    checkBit("HRESP on idle transfer", lastResp, 1'b0);
    checkBit("DataAccessFault on idle transfer", lastFault, 1'b0);
  endtask

  task automatic timerTest();
    logic [31:0] t1;
    logic [31:0] t2;
    int          waited;
    busRead(MtimeLoAddr, t1);
    busRead(MtimeLoAddr, t2);
    checkBit("mtime advancing between reads", t2 > t1, 1'b1);
    busWrite(CmpHiAddr, SizeWord, 32'h0);
    busWrite(CmpLoAddr, SizeWord, t2 + 32'd50);
    idleCycles(2);
    checkBit("TimerInt right after compare write", TimerInt, 1'b0);
    waited = 0;
    while (TimerInt !== 1'b1 && waited < 200) begin
      idleCycles(1);
      waited++;
    end
    checkBit("TimerInt within 200 cycles", TimerInt, 1'b1);
    busWrite(CmpLoAddr, SizeWord, 32'hFFFF_FFFF);
    busWrite(CmpHiAddr, SizeWord, 32'hFFFF_FFFF);
    idleCycles(2);
    checkBit("TimerInt with all-ones compare", TimerInt, 1'b0);
  endtask

  task automatic swIntTest();
    busWrite(MsipAddr, SizeWord, 32'h1);
    idleCycles(2);
    checkBit("SwInt after msip set", SwInt, 1'b1);
    busWrite(MsipAddr, SizeWord, 32'h0);
    idleCycles(2);
    checkBit("SwInt after msip clear", SwInt, 1'b0);
  endtask

  task automatic gpioTest();
    logic [31:0] en;
    logic [31:0] out;
    logic [31:0] pins;
    logic [31:0] got;
    en  = $random(seed);
    out = $random(seed);
    busWrite(GpioEnAddr, SizeWord, en);
    busWrite(GpioOutAddr, SizeWord, out);
    idleCycles(2);
    checkData("GPIOPinsEn", GPIOPinsEn, en);
    checkData("GPIOPinsOut", GPIOPinsOut, out);
    // Pins change on the falling edge, then settle through the synchronizer
    pins = $random(seed);
    GPIOPinsIn = pins;
    idleCycles(3);
    busRead(GpioInAddr, got);
    checkData("GPIO input register", got, pins);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    arstN      = 1'b0;
    HADDR      = 32'h0;
    HTRANS     = TransIdle;
    HSIZE      = SizeWord;
    HWRITE     = 1'b0;
    HWDATA     = 32'h0;
    GPIOPinsIn = 32'h0;
    pendWdata  = 32'h0;
    repeat (3) @(posedge HCLK);
    @(negedge HCLK);
    arstN = 1'b1;

    memTest(`UNCORE_TIMBASE, `UNCORE_TIMDEPTH);
    memTest(`UNCORE_BOOTBASE, `UNCORE_BOOTDEPTH);
    partialWrite(`UNCORE_TIMBASE + 32'h42, SizeByte);
    partialWrite(`UNCORE_TIMBASE + 32'h41, SizeByte);
    partialWrite(`UNCORE_BOOTBASE + 32'h12, SizeHalf);
    partialWrite(`UNCORE_BOOTBASE + 32'h10, SizeHalf);
    unmappedTest();
    timerTest();
    swIntTest();
    gpioTest();
    idleCycles(2);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/uncore_asserts.sv ====
// Concurrent checks on the uncore bus outputs and interrupts
// Bound into the top level from the testbench

`timescale 1ns/100ps
`default_nettype none

module uncore_asserts import uncorePkg::*; (
  input logic   HCLK,
  input logic   arstN,
  input htransT HTRANS,
  input logic   HREADY,
  input logic   HRESP,
  input logic   DataAccessFault,
  input logic   TimerInt,
  input logic   SwInt
);

  // Set once any active transfer has been issued
  logic sawXfer;
  // Sticky flag for each property
  logic readyBad = 1'b0;
  logic respBad  = 1'b0;
  logic quietBad = 1'b0;
  logic idleBad  = 1'b0;
  logic anyFail;

  assign anyFail = readyBad | respBad | quietBad | idleBad;

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      sawXfer <= 1'b0;
    end else if (HTRANS == TransNonseq || HTRANS == TransSeq) begin
      sawXfer <= 1'b1;
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  // Zero wait states
  readyHigh: assert property (@(posedge HCLK) disable iff (!arstN) HREADY)
    else begin
      readyBad = 1'b1;
      $error("HREADY low in a zero wait state system");
    end

  respMatch: assert property (@(posedge HCLK) disable iff (!arstN) HRESP == DataAccessFault)
    else begin
      respBad = 1'b1;
      $error("HRESP and DataAccessFault disagree");
    end

  // Nothing fires before the first transfer
  quietAfterReset: assert property (@(posedge HCLK) disable iff (!arstN)
                                    !sawXfer |-> (!HRESP && !TimerInt && !SwInt))
    else begin
      quietBad = 1'b1;
      $error("Response or interrupt raised before any transfer");
    end

  idleNoResp: assert property (@(posedge HCLK) disable iff (!arstN)
                               (HTRANS == TransIdle) |=> !HRESP)
    else begin
      idleBad = 1'b1;
      $error("HRESP raised in the data phase of an idle transfer");
    end

endmodule

`default_nettype wire

// ==== uncore.f ====
+incdir+src
src/uncorePkg.sv
src/ahbDecoder.sv
src/dtim.sv
src/clint.sv
src/gpio.sv
src/uncore.sv
tests/uncore_asserts.sv
tests/uncoreTb.sv
